// ==== core_region.f ====
src/core_region_pkg.sv
src/sp_ram.sv
src/ram_mux.sv
src/lsu_demux.sv
src/core_region.sv
test/core_region_checker.sv
test/tb_core_region.sv

// ==== src/core_region.sv ====
`timescale 1ns/100ps

module core_region
  import core_region_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // Core data channel
  input  logic     lsu_req_i,
  input  mem_req_t lsu_i,
  output logic     lsu_gnt_o,
  output logic     lsu_rvalid_o,
  output word_t    lsu_rdata_o,

  // Core instruction channel
  input  logic     fetch_req_i,
  input  addr_t    fetch_addr_i,
  output logic     fetch_gnt_o,
  output logic     fetch_rvalid_o,
  output word_t    fetch_rdata_o,

  // Outgoing bus
  output logic     bus_req_o,
  output mem_req_t bus_o,
  input  logic     bus_gnt_i,
  input  logic     bus_rvalid_i,
  input  word_t    bus_rdata_i,

  // Load ports
  input  logic     iload_req_i,
  input  mem_req_t iload_i,
  output word_t    iload_rdata_o,
  input  logic     dload_req_i,
  input  mem_req_t dload_i,
  output word_t    dload_rdata_o
);

  // Decoder to data RAM arbiter
  logic      data_req;
  mem_req_t  data_lsu;
  logic      data_gnt;
  logic      data_rvalid;
  word_t     data_rdata;

  // Fetches never write
  mem_req_t  fetch_req;

  logic      instr_en;
  logic      instr_we;
  ram_addr_t instr_addr;
  byte_en_t  instr_be;
  word_t     instr_wdata;
  word_t     instr_rdata;

  logic      dram_en;
  logic      dram_we;
  ram_addr_t dram_addr;
  byte_en_t  dram_be;
  word_t     dram_wdata;
  word_t     dram_rdata;

  assign fetch_req = '{addr: fetch_addr_i, we: 1'b0, be: '1, wdata: '0};

  lsu_demux lsu_demux_i (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_i        ( lsu_i        ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .ram_req_o    ( data_req     ),
    .ram_o        ( data_lsu     ),
    .ram_gnt_i    ( data_gnt     ),
    .ram_rvalid_i ( data_rvalid  ),
    .ram_rdata_i  ( data_rdata   ),
    .bus_req_o    ( bus_req_o    ),
    .bus_o        ( bus_o        ),
    .bus_gnt_i    ( bus_gnt_i    ),
    .bus_rvalid_i ( bus_rvalid_i ),
    .bus_rdata_i  ( bus_rdata_i  )
  );

  ram_mux instr_ram_mux_i (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .port0_req_i    ( iload_req_i    ),
    .port0_i        ( iload_i        ),
    .port0_rdata_o  ( iload_rdata_o  ),
    .port1_req_i    ( fetch_req_i    ),
    .port1_i        ( fetch_req      ),
    .port1_gnt_o    ( fetch_gnt_o    ),
    .port1_rvalid_o ( fetch_rvalid_o ),
    .port1_rdata_o  ( fetch_rdata_o  ),
    .ram_en_o       ( instr_en       ),
    .ram_we_o       ( instr_we       ),
    .ram_addr_o     ( instr_addr     ),
    .ram_be_o       ( instr_be       ),
    .ram_wdata_o    ( instr_wdata    ),
    .ram_rdata_i    ( instr_rdata    )
  );

  sp_ram instr_ram_i (
    .clk     ( clk         ),
    .en_i    ( instr_en    ),
    .we_i    ( instr_we    ),
    .addr_i  ( instr_addr  ),
    .be_i    ( instr_be    ),
    .wdata_i ( instr_wdata ),
    .rdata_o ( instr_rdata )
  );

  ram_mux data_ram_mux_i (
    .clk            ( clk           ),
    .rst_n          ( rst_n         ),
    .port0_req_i    ( dload_req_i   ),
    .port0_i        ( dload_i       ),
    .port0_rdata_o  ( dload_rdata_o ),
    .port1_req_i    ( data_req      ),
    .port1_i        ( data_lsu      ),
    .port1_gnt_o    ( data_gnt      ),
    .port1_rvalid_o ( data_rvalid   ),
    .port1_rdata_o  ( data_rdata    ),
    .ram_en_o       ( dram_en       ),
    .ram_we_o       ( dram_we       ),
    .ram_addr_o     ( dram_addr     ),
    .ram_be_o       ( dram_be       ),
    .ram_wdata_o    ( dram_wdata    ),
    .ram_rdata_i    ( dram_rdata    )
  );

  sp_ram data_ram_i (
    .clk     ( clk        ),
    .en_i    ( dram_en    ),
    .we_i    ( dram_we    ),
    .addr_i  ( dram_addr  ),
    .be_i    ( dram_be    ),
    .wdata_i ( dram_wdata ),
    .rdata_o ( dram_rdata )
  );

endmodule

// ==== src/core_region_pkg.sv ====
package core_region_pkg;

  // Address bits 31:20 that select the local data RAM
  localparam int unsigned REGION_BITS = 12;
  localparam logic [REGION_BITS-1:0] LOCAL_REGION = 12'h001;

  // RAM geometry, word addressed
  localparam int unsigned RAM_WORDS_LOG2 = 10;
  localparam int unsigned RAM_WORDS = 1 << RAM_WORDS_LOG2;

  // Byte offset inside a 32-bit word
  localparam int unsigned BYTE_OFS_BITS = 2;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0] byte_en_t;
  typedef logic [RAM_WORDS_LOG2-1:0] ram_addr_t;

  // Payload of every request channel
  typedef struct packed {
    addr_t    addr;
    logic     we;
    byte_en_t be;
    word_t    wdata;
  } mem_req_t;

  // Where the next core data response comes from
  typedef enum logic {
    RESP_RAM,
    RESP_BUS
  } resp_src_e;

endpackage

// ==== src/lsu_demux.sv ====
`timescale 1ns/100ps

module lsu_demux
  import core_region_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // Core load/store channel
  input  logic     lsu_req_i,
  input  mem_req_t lsu_i,
  output logic     lsu_gnt_o,
  output logic     lsu_rvalid_o,
  output word_t    lsu_rdata_o,

  // Local data RAM
  output logic     ram_req_o,
  output mem_req_t ram_o,
  input  logic     ram_gnt_i,
  input  logic     ram_rvalid_i,
  input  word_t    ram_rdata_i,

  // External bus
  output logic     bus_req_o,
  output mem_req_t bus_o,
  input  logic     bus_gnt_i,
  input  logic     bus_rvalid_i,
  input  word_t    bus_rdata_i
);

  logic      is_local;
  resp_src_e resp_src_q;
  resp_src_e resp_src_d;

  assign is_local = (lsu_i.addr[$bits(addr_t)-1 -: REGION_BITS] == LOCAL_REGION);

  assign ram_req_o = lsu_req_i & is_local;
  assign bus_req_o = lsu_req_i & ~is_local;

  // Same payload to both targets, only req is steered
  assign ram_o = lsu_i;
  assign bus_o = lsu_i;

  always_comb
  begin
    resp_src_d = resp_src_q;
    lsu_gnt_o  = 1'b0;
    if (ram_req_o)
    begin
      lsu_gnt_o  = ram_gnt_i;
      resp_src_d = RESP_RAM;
    end
    else if (bus_req_o)
    begin
      lsu_gnt_o  = bus_gnt_i;
      resp_src_d = RESP_BUS;
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      resp_src_q <= RESP_RAM;
    end
    else
    begin
      resp_src_q <= resp_src_d;
    end
  end

  // Response back to the core
  assign lsu_rvalid_o = ram_rvalid_i | bus_rvalid_i;
  assign lsu_rdata_o  = (resp_src_q == RESP_BUS) ? bus_rdata_i : ram_rdata_i;

endmodule

// ==== src/ram_mux.sv ====
`timescale 1ns/100ps

module ram_mux
  import core_region_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Load port, never refused
  input  logic      port0_req_i,
  input  mem_req_t  port0_i,
  output word_t     port0_rdata_o,

  // Core port
  input  logic      port1_req_i,
  input  mem_req_t  port1_i,
  output logic      port1_gnt_o,
  output logic      port1_rvalid_o,
  output word_t     port1_rdata_o,

  // Single-port RAM side
  output logic      ram_en_o,
  output logic      ram_we_o,
  output ram_addr_t ram_addr_o,
  output byte_en_t  ram_be_o,
  output word_t     ram_wdata_o,
  input  word_t     ram_rdata_i
);

  mem_req_t sel_req;
  logic     port1_rvalid_q;

  // Port 0 has fixed priority
  assign port1_gnt_o = port1_req_i & ~port0_req_i;

  always_comb
  begin
    if (port0_req_i)
    begin
      sel_req = port0_i;
    end
    else
    begin
      sel_req = port1_i;
    end
  end

  assign ram_en_o    = port0_req_i | port1_req_i;
  assign ram_we_o    = sel_req.we;
  // Word index sits just above the byte offset
  assign ram_addr_o  = sel_req.addr[BYTE_OFS_BITS +: RAM_WORDS_LOG2];
  assign ram_be_o    = sel_req.be;
  assign ram_wdata_o = sel_req.wdata;

  // Remember a port 1 grant, the RAM answers one cycle later
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      port1_rvalid_q <= 1'b0;
    end
    else
    begin
      port1_rvalid_q <= port1_gnt_o;
    end
  end

  assign port1_rvalid_o = port1_rvalid_q;

  // Read data is shared, each side knows when it is valid
  assign port0_rdata_o = ram_rdata_i;
  assign port1_rdata_o = ram_rdata_i;

endmodule

// ==== src/sp_ram.sv ====
`timescale 1ns/100ps

module sp_ram
  import core_region_pkg::*;
(
  input  logic      clk,
  input  logic      en_i,
  input  logic      we_i,
  input  ram_addr_t addr_i,
  input  byte_en_t  be_i,
  input  word_t     wdata_i,
  output word_t     rdata_o
);

  word_t mem [RAM_WORDS];

  // One access per enabled cycle, write or read
  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        // Only the enabled byte lanes change
        for (int i = 0; i < $bits(byte_en_t); i++)
        begin
          if (be_i[i])
          begin
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      else
      begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// ==== test/core_region_checker.sv ====
`timescale 1ns/100ps

module core_region_checker
  import core_region_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     lsu_req_i,
  input  mem_req_t lsu_i,
  input  logic     lsu_gnt_i,
  input  logic     lsu_rvalid_i,
  input  word_t    lsu_rdata_i,
  input  logic     fetch_req_i,
  input  logic     fetch_gnt_i,
  input  logic     fetch_rvalid_i,
  input  word_t    fetch_rdata_i,
  input  logic     bus_req_i,
  input  mem_req_t bus_i,
  input  logic     bus_gnt_i,
  input  logic     iload_req_i,
  input  word_t    iload_rdata_i,
  input  logic     dload_req_i,
  input  word_t    dload_rdata_i
);

  typedef struct packed {
    int unsigned idx;
    logic        check;
    word_t       value;
  } expect_t;

  // One queue per channel indexed by kind (0 dload, 1 iload, 2 lsu, 3 fetch)
  expect_t q [4][$];
  int unsigned passed = 0;
  int unsigned failed = 0;
  int unsigned timing_errors = 0;
  logic dload_pend = 1'b0;
  logic iload_pend = 1'b0;
  logic local_gnt_q = 1'b0;
  logic fetch_gnt_q = 1'b0;
  logic lsu_local;

  assign lsu_local = (lsu_i.addr[31:20] == LOCAL_REGION);

  task automatic push_expect(input int kind, input int unsigned idx, input logic check,
                             input word_t value);
    expect_t e;
    e.idx = idx;
    e.check = check;
    e.value = value;
    q[kind].push_back(e);
  endtask

  task automatic compare(input int kind, input string name, input word_t got);
    expect_t e;
    if (q[kind].size() == 0)
    begin
      $display("Unexpected response on %s with no request outstanding", name);
      failed++;
    end
    else
    begin
      e = q[kind].pop_front();
      if (e.check && got !== e.value)
      begin
        $display("** Error t=%0t test %0d: %s = %h, expected %h", $time, e.idx, name, got,
                 e.value);
        $display("test %0d (%s) failed", e.idx, name);
        failed++;
      end
      else
      begin
        $display("test %0d (%s) passed", e.idx, name);
        passed++;
      end
    end
  endtask

  task automatic timing_error(input string msg);
    $display("Timing error at t=%0t: %s", $time, msg);
    timing_errors++;
  endtask

  function automatic logic idle();
    return q[0].size() == 0 && q[1].size() == 0 && q[2].size() == 0 &&
           q[3].size() == 0 && !dload_pend && !iload_pend;
  endfunction

  function automatic int unsigned total_errors();
    return failed + timing_errors + q[0].size() + q[1].size() + q[2].size() + q[3].size();
  endfunction

  task automatic report();
    $display("Summary: %0d passed, %0d failed, %0d timing errors, %0d unanswered", passed,
             failed, timing_errors, q[0].size() + q[1].size() + q[2].size() + q[3].size());
  endtask

  // Sampled mid-cycle where all strobes have settled
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      if (lsu_gnt_i || lsu_rvalid_i || fetch_gnt_i || fetch_rvalid_i || bus_req_i)
        timing_error("grant, valid or bus request high during reset");
    end
    else
    begin
      if (dload_pend)
        compare(0, "dload_rdata_o", dload_rdata_i);
      if (iload_pend)
        compare(1, "iload_rdata_o", iload_rdata_i);
      if (lsu_rvalid_i)
        compare(2, "lsu_rdata_o", lsu_rdata_i);
      if (fetch_rvalid_i)
        compare(3, "fetch_rdata_o", fetch_rdata_i);

      if (local_gnt_q && !lsu_rvalid_i)
        timing_error("local lsu response missing one cycle after grant");
      if (fetch_gnt_q != fetch_rvalid_i)
        timing_error("fetch_rvalid_o not exactly one cycle after grant");
      if (lsu_gnt_i && !lsu_req_i)
        timing_error("lsu_gnt_o high without a request");
      if (fetch_gnt_i && !fetch_req_i)
        timing_error("fetch_gnt_o high without a request");
      if (lsu_req_i && lsu_local && !dload_req_i && !lsu_gnt_i)
        timing_error("local lsu request not granted while the data RAM is free");
      if (fetch_req_i && !iload_req_i && !fetch_gnt_i)
        timing_error("fetch request not granted while the instruction RAM is free");
      if (bus_req_i && (!lsu_req_i || lsu_local))
        timing_error("bus_req_o high without a non-local request");
      if (lsu_req_i && lsu_local && dload_req_i && lsu_gnt_i)
        timing_error("lsu granted while the load port owns the data RAM");
      if (bus_req_i && lsu_gnt_i !== bus_gnt_i)
        timing_error("lsu_gnt_o does not follow bus_gnt_i");
      if (bus_req_i && bus_i !== lsu_i)
      begin
        $display("** Error t=%0t: bus_o = %h, expected %h", $time, bus_i, lsu_i);
        timing_errors++;
      end
    end

    dload_pend  = rst_n && dload_req_i;
    iload_pend  = rst_n && iload_req_i;
    local_gnt_q = rst_n && lsu_req_i && lsu_gnt_i && lsu_local;
    fetch_gnt_q = rst_n && fetch_gnt_i;
  end

endmodule

// ==== test/core_region_testdata.txt ====
// Columns: op (0 dload, 1 iload, 2 lsu, 3 fetch, 4 lsu with dload read), we, addr, be,
// wdata, expected read value. Non-local bus reads expect addr ^ a5a5a5a5
0 1 00100010 f 11223344 00000000
0 1 00100010 5 aa00bb00 00000000
0 0 00100010 0 00000000 11003300
2 1 00100020 f cafef00d 00000000
2 0 00100020 0 00000000 cafef00d
4 0 00100010 0 00000000 11003300
2 0 40000100 0 00000000 e5a5a4a5
2 1 40000200 f 12345678 00000000
2 0 80001000 0 00000000 25a5b5a5
2 0 00100020 0 00000000 cafef00d
1 1 00000000 f 00000013 00000000
1 1 00000004 f 00a00093 00000000
1 1 00000008 f 00b00113 00000000
3 0 00000000 0 00000000 00000013
3 0 00000004 0 00000000 00a00093
3 0 00000008 0 00000000 00b00113

// ==== test/tb_core_region.sv ====
`timescale 1ns/100ps

module tb_core_region
  import core_region_pkg::*;
();

  localparam word_t BUS_PATTERN = 32'ha5a5a5a5;
  localparam int MAX_LINES = 64;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic lsu_req_i, fetch_req_i, bus_gnt_i, bus_rvalid_i, iload_req_i, dload_req_i;
  mem_req_t lsu_i, iload_i, dload_i;
  addr_t fetch_addr_i;
  word_t bus_rdata_i;
  logic lsu_gnt_o, lsu_rvalid_o, fetch_gnt_o, fetch_rvalid_o, bus_req_o;
  word_t lsu_rdata_o, fetch_rdata_o, iload_rdata_o, dload_rdata_o;
  mem_req_t bus_o;

  word_t td [0:6*MAX_LINES-1];
  int n_lines = 0;
  int unsigned cycle_limit = 100000;
  int unsigned cycles = 0;
  logic [31:0] seed = 32'd97086;

  core_region core_region_i (.*);

  core_region_checker checker_i (
    .clk(clk), .rst_n(rst_n),
    .lsu_req_i(lsu_req_i), .lsu_i(lsu_i), .lsu_gnt_i(lsu_gnt_o),
    .lsu_rvalid_i(lsu_rvalid_o), .lsu_rdata_i(lsu_rdata_o),
    .fetch_req_i(fetch_req_i), .fetch_gnt_i(fetch_gnt_o),
    .fetch_rvalid_i(fetch_rvalid_o), .fetch_rdata_i(fetch_rdata_o),
    .bus_req_i(bus_req_o), .bus_i(bus_o), .bus_gnt_i(bus_gnt_i),
    .iload_req_i(iload_req_i), .iload_rdata_i(iload_rdata_o),
    .dload_req_i(dload_req_i), .dload_rdata_i(dload_rdata_o)
  );

  always #4 clk = ~clk;

  function automatic int unsigned next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 16;
  endfunction

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Bus slave with random grant and response delays
  initial
  begin
    addr_t a;
    bus_gnt_i = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rdata_i = '0;
    forever
    begin
      @(posedge clk);
      #2;
      if (bus_req_o)
      begin
        a = bus_o.addr;
        repeat (next_rand() % 4)
        begin
          @(posedge clk);
          #2;
        end
        bus_gnt_i = 1'b1;
        @(posedge clk);
        #2;
        bus_gnt_i = 1'b0;
        repeat (next_rand() % 4)
        begin
          @(posedge clk);
          #2;
        end
        bus_rvalid_i = 1'b1;
        bus_rdata_i = a ^ BUS_PATTERN;
        @(posedge clk);
        #2;
        bus_rvalid_i = 1'b0;
      end
    end
  end

  task automatic lsu_access(input int idx, input mem_req_t r, input word_t exp,
                            input logic with_dload);
    lsu_req_i = 1'b1;
    lsu_i = r;
    checker_i.push_expect(2, idx, !r.we, exp);
    if (with_dload)
    begin
      dload_req_i = 1'b1;
      dload_i = r;
      checker_i.push_expect(0, idx, 1'b1, exp);
    end
    @(negedge clk);
    while (!lsu_gnt_o)
    begin
      @(posedge clk);
      #1;
      dload_req_i = 1'b0;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    lsu_req_i = 1'b0;
    dload_req_i = 1'b0;
    while (!lsu_rvalid_o)
      @(negedge clk);
  endtask

  initial
  begin
    mem_req_t r;
    lsu_req_i = 1'b0;
    fetch_req_i = 1'b0;
    iload_req_i = 1'b0;
    dload_req_i = 1'b0;
    lsu_i = '0;
    iload_i = '0;
    dload_i = '0;
    fetch_addr_i = '0;
    // All ones in the op column marks an unused line
    for (int k = 0; k < MAX_LINES; k++)
      td[6*k] = '1;
    $readmemh("test/core_region_testdata.txt", td);
    while (n_lines < MAX_LINES && td[6*n_lines] !== '1)
      n_lines++;
    cycle_limit = 20 * n_lines + 100;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < n_lines; i++)
    begin
      r = '{addr: td[6*i+2], we: td[6*i+1][0], be: td[6*i+3][3:0], wdata: td[6*i+4]};
      @(posedge clk);
      #1;
      if (td[6*i] != 3)
        fetch_req_i = 1'b0;
      case (td[6*i])
        0, 1:
        begin
          if (td[6*i] == 0)
          begin
            dload_req_i = 1'b1;
            dload_i = r;
          end
          else
          begin
            iload_req_i = 1'b1;
            iload_i = r;
          end
          checker_i.push_expect(td[6*i], i, !r.we, td[6*i+5]);
          @(posedge clk);
          #1;
          dload_req_i = 1'b0;
          iload_req_i = 1'b0;
          if (td[6*i] == 1 && r.we && r.be == '1)
          begin
            // Read the full word back through the load port
            iload_req_i = 1'b1;
            iload_i.we = 1'b0;
            checker_i.push_expect(1, i, 1'b1, r.wdata);
            @(posedge clk);
            #1;
            iload_req_i = 1'b0;
          end
        end
        2, 4:
          lsu_access(i, r, td[6*i+5], td[6*i] == 4);
        default:
        begin
          // Fetches stay back to back while the next line changes the address
          fetch_req_i = 1'b1;
          fetch_addr_i = r.addr;
          checker_i.push_expect(3, i, 1'b1, td[6*i+5]);
          @(negedge clk);
          while (!fetch_gnt_o)
            @(negedge clk);
        end
      endcase
    end
    @(posedge clk);
    #1;
    fetch_req_i = 1'b0;
    @(negedge clk);
    while (!checker_i.idle())
      @(negedge clk);
    repeat (2) @(negedge clk);

    checker_i.report();
    if (checker_i.total_errors() == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
